// ==== vlog.f ====
logic/mem_stage_pkg.sv
logic/mem_control.sv
logic/pipe_stage.sv
logic/data_ram.sv
logic/load_align.sv
logic/mem_stage_top.sv
verif/mem_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the data-memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module mem_stage_tb \
    -f vlog.f \
    -o mem_stage_sim \
    && ./obj_dir/mem_stage_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error"

cat sim.log 2>/dev/null

grep -q "^Test passed$" sim.log \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }

exit 0

// ==== verif/mem_stage_tb.sv ====
`timescale 1ns/1ps

module mem_stage_tb
    import mem_stage_pkg::*;
();

    localparam int n_random    = 400;
    localparam int total_reqs  = 288 + n_random;          // directed plus random
    localparam int cycle_limit = total_reqs * 4 + 200;
    localparam logic [5:0] op_other = 6'b001000;          // addi opcode is no memory op

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        req_valid = 1'b0;
    logic        req_ready;
    logic [31:0] req_instr = 32'h0;
    logic [31:0] req_addr = 32'h0;
    logic [31:0] req_wdata = 32'h0;
    logic        resp_valid;
    logic        resp_ready = 1'b0;
    logic [31:0] resp_rdata;
    logic        resp_load_error;
    logic        resp_store_error;

    logic [31:0] lfsr_q = 32'd76232;                      // stimulus stream
    logic [31:0] ready_lfsr = 32'd76232;                  // back-pressure stream
    logic        random_ready = 1'b0;
    logic [31:0] model [ram_words];                       // reference copy of the RAM
    logic [31:0] exp_rdata_q [16];
    logic        exp_lerr_q [16];
    logic        exp_serr_q [16];
    int          req_cnt = 0;
    int          resp_cnt = 0;
    int          err_count = 0;
    int          err_mark = 0;
    int          cycle_cnt = 0;
    logic [3:0]  head_idx;
    logic [31:0] head_rdata;
    logic        head_lerr;
    logic        head_serr;

    mem_stage_top UUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .req_valid        (req_valid),
        .req_ready        (req_ready),
        .req_instr        (req_instr),
        .req_addr         (req_addr),
        .req_wdata        (req_wdata),
        .resp_valid       (resp_valid),
        .resp_ready       (resp_ready),
        .resp_rdata       (resp_rdata),
        .resp_load_error  (resp_load_error),
        .resp_store_error (resp_store_error)
    );

    initial begin
        forever begin
            #10;
            clk = ~clk;
        end
    end

    // taps 32 22 2 1 with the new bit shifted in at the bottom
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'h0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [5:0] pick_op(input logic [2:0] sel);
        case (sel)
            3'd0:    return op_lw;
            3'd1:    return op_lh;
            3'd2:    return op_lhu;
            3'd3:    return op_lb;
            3'd4:    return op_lbu;
            3'd5:    return op_sw;
            3'd6:    return op_sh;
            default: return op_sb;
        endcase
    endfunction

    function automatic logic load_fault(input logic [5:0] op, input logic [1:0] off);
        return (op == op_lw && off != 2'd0) || ((op == op_lh || op == op_lhu) && off[0]);
    endfunction

    function automatic logic store_fault(input logic [5:0] op, input logic [1:0] off);
        return (op == op_sw && off != 2'd0) || (op == op_sh && off[0]);
    endfunction

    function automatic logic [31:0] expect_rdata(input logic [5:0] op, input logic [1:0] off,
                                                 input logic [31:0] w);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*off +: 8];
        h = off[1] ? w[31:16] : w[15:0];
        case (op)
            op_lw:   return w;
            op_lh:   return {{16{h[15]}}, h};
            op_lhu:  return {16'h0, h};
            op_lb:   return {{24{b[7]}}, b};
            op_lbu:  return {24'h0, b};
            default: return 32'h0;                        // stores and other opcodes
        endcase
    endfunction

    function automatic logic [31:0] merge_store(input logic [5:0] op, input logic [1:0] off,
                                                input logic [31:0] wd, input logic [31:0] w);
        logic [31:0] r;
        r = w;
        if (op == op_sw && off == 2'd0) begin
            r = wd;
        end else if (op == op_sh && !off[0]) begin
            r[16*off[1] +: 16] = wd[15:0];
        end else if (op == op_sb) begin
            r[8*off +: 8] = wd[7:0];
        end
        return r;
    endfunction

    // reference model updated in acceptance order
    always @(posedge clk) begin
        logic [5:0]            op;
        logic [1:0]            off;
        logic [ram_addr_w-1:0] idx;
        if (rst_n) begin
            if (req_valid && req_ready) begin
                op  = req_instr[31:26];
                off = req_addr[1:0];
                idx = req_addr[ram_addr_w+1:2];
                exp_rdata_q[req_cnt[3:0]] <= load_fault(op, off) ? 32'h0
                                           : expect_rdata(op, off, model[idx]);
                exp_lerr_q[req_cnt[3:0]] <= load_fault(op, off);
                exp_serr_q[req_cnt[3:0]] <= store_fault(op, off);
                model[idx] <= merge_store(op, off, req_wdata, model[idx]);
                req_cnt <= req_cnt + 1;
            end
            if (resp_valid && resp_ready) begin
                resp_cnt <= resp_cnt + 1;
            end
        end
    end

    assign head_idx   = resp_cnt[3:0];
    assign head_rdata = exp_rdata_q[head_idx];
    assign head_lerr  = exp_lerr_q[head_idx];
    assign head_serr  = exp_serr_q[head_idx];

    always @(posedge clk) begin
        if (random_ready) begin
            ready_lfsr = lfsr_next(ready_lfsr);
            resp_ready <= ready_lfsr[0];                   // one bit per cycle
        end else begin
            resp_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        req_cnt == 0 |-> !resp_valid && req_ready)
        else begin
            $display("response side active or request side blocked before the first request");
            err_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> resp_cnt < req_cnt)
        else begin
            $display("response seen with no request pending");
            err_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && resp_ready |-> resp_rdata == head_rdata)
        else begin
            $display("error resp_rdata expected %h got %h",
                     $sampled(head_rdata), $sampled(resp_rdata));
            err_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && resp_ready |-> resp_load_error == head_lerr)
        else begin
            $display("error resp_load_error expected %h got %h",
                     $sampled(head_lerr), $sampled(resp_load_error));
            err_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && resp_ready |-> resp_store_error == head_serr)
        else begin
            $display("error resp_store_error expected %h got %h",
                     $sampled(head_serr), $sampled(resp_store_error));
            err_count++;
        end

    // a stalled response keeps its data and flags
    assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata)
            && $stable(resp_load_error) && $stable(resp_store_error))
        else begin
            $display("stalled response changed or vanished");
            err_count++;
        end

    task automatic send_req(input logic [5:0] op, input logic [31:0] addr,
                            input logic [31:0] data);
        logic [31:0] r;
        r = rand_bits(26);
        req_valid <= 1'b1;
        req_instr <= {op, r[25:0]};                        // low bits are don't care
        req_addr  <= addr;
        req_wdata <= data;
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        req_valid <= 1'b0;
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        while (resp_cnt != req_cnt) begin
            @(posedge clk);
        end
        $display("test %s done, %0d errors", name, err_count - err_mark);
        err_mark = err_count;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] g;
        logic [31:0] s;
        logic [5:0]  op;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);
        end_test("reset_idle");

        for (int i = 0; i < ram_words; i++) begin
            r = rand_bits(32);
            send_req(op_sw, i << 2, r);
        end
        end_test("fill");

        send_req(op_sw, 32'h40, 32'hcafe1234);
        send_req(op_lw, 32'h40, 32'h0);
        end_test("sw_lw");

        send_req(op_sw, 32'h80, 32'h11223344);
        send_req(op_sb, 32'h81, 32'h000000aa);
        send_req(op_sh, 32'h82, 32'h0000bbcc);
        send_req(op_lw, 32'h80, 32'h0);
        end_test("lane_merge");

        send_req(op_sw, 32'hc0, 32'h80f17f8e);             // sign bits in mixed lanes
        for (int k = 0; k < 4; k++) begin
            send_req(op_lb, 32'hc0 + k, 32'h0);
            send_req(op_lbu, 32'hc0 + k, 32'h0);
        end
        for (int k = 0; k < 4; k += 2) begin
            send_req(op_lh, 32'hc0 + k, 32'h0);
            send_req(op_lhu, 32'hc0 + k, 32'h0);
        end
        end_test("sub_word_loads");

        for (int k = 1; k < 4; k++) begin
            send_req(op_lw, 32'hc0 + k, 32'h0);
            send_req(op_sw, 32'hc0 + k, 32'hdeadbeef);
        end
        for (int k = 1; k < 4; k += 2) begin
            send_req(op_lh, 32'hc0 + k, 32'h0);
            send_req(op_lhu, 32'hc0 + k, 32'h0);
            send_req(op_sh, 32'hc0 + k, 32'h0000beef);
        end
        send_req(op_lw, 32'hc0, 32'h0);                    // word must be untouched
        end_test("misaligned");

        random_ready <= 1'b1;
        for (int n = 0; n < n_random; n++) begin
            g = rand_bits(2);
            if (g[1:0] == 2'd0) begin
                @(posedge clk);                            // idle gap
            end
            s  = rand_bits(6);
            op = (s[5:3] == 3'd0) ? op_other : pick_op(s[2:0]);
            r  = rand_bits(32);
            send_req(op, r, rand_bits(32));
        end
        end_test("random_backpressure");
        random_ready <= 1'b0;

        $display("requests %0d, responses %0d, errors %0d", req_cnt, resp_cnt, err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== logic/mem_stage_top.sv ====
`timescale 1ns/1ps

module mem_stage_top
    import mem_stage_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    output logic        req_ready,
    input  logic [31:0] req_instr,
    input  logic [31:0] req_addr,
    input  logic [31:0] req_wdata,
    output logic        resp_valid,
    input  logic        resp_ready,
    output logic [31:0] resp_rdata,
    output logic        resp_load_error,
    output logic        resp_store_error
);

    logic [3:0]    dec_byte_en;
    logic [31:0]   dec_store_data;
    load_kind_t    dec_load_kind;
    logic          dec_load_error;
    logic          dec_store_error;

    req_payload_t  req_in;
    req_payload_t  s1_data;
    logic          s1_valid;
    logic          s1_ready;
    logic          s1_xfer;                    // stage 1 to stage 2 move

    resp_payload_t resp_in;
    resp_payload_t s2_data;

    logic [3:0]    ram_byte_en;
    logic [31:0]   ram_rdata;

    mem_control u_mem_control (
        .instr       (req_instr),
        .addr        (req_addr),
        .wdata       (req_wdata),
        .byte_en     (dec_byte_en),
        .store_data  (dec_store_data),
        .load_kind   (dec_load_kind),
        .load_error  (dec_load_error),
        .store_error (dec_store_error)
    );

    assign req_in = '{
        word_idx:    req_addr[ram_addr_w+1:2],
        byte_en:     dec_byte_en,
        wdata:       dec_store_data,
        load_kind:   dec_load_kind,
        offset:      req_addr[1:0],
        load_error:  dec_load_error,
        store_error: dec_store_error
    };

    pipe_stage #(.payload_t(req_payload_t)) u_req_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req_in),
        .out_valid (s1_valid),
        .out_ready (s1_ready),
        .out_data  (s1_data)
    );

    // RAM works only on the edge that hands the item to stage 2
    assign s1_xfer     = s1_valid & s1_ready;
    assign ram_byte_en = s1_xfer ? s1_data.byte_en : 4'b0000;

    data_ram u_data_ram (
        .clk       (clk),
        .en        (s1_xfer),
        .word_addr (s1_data.word_idx),
        .byte_en   (ram_byte_en),
        .wdata     (s1_data.wdata),
        .rdata     (ram_rdata)
    );

    assign resp_in = '{
        load_kind:   s1_data.load_kind,
        offset:      s1_data.offset,
        load_error:  s1_data.load_error,
        store_error: s1_data.store_error
    };

    pipe_stage #(.payload_t(resp_payload_t)) u_resp_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (s1_valid),
        .in_ready  (s1_ready),
        .in_data   (resp_in),
        .out_valid (resp_valid),
        .out_ready (resp_ready),
        .out_data  (s2_data)
    );

    load_align u_load_align (
        .rword     (ram_rdata),
        .load_kind (s2_data.load_kind),
        .offset    (s2_data.offset),
        .rdata     (resp_rdata)
    );

    assign resp_load_error  = s2_data.load_error;
    assign resp_store_error = s2_data.store_error;

endmodule

// ==== logic/load_align.sv ====
`timescale 1ns/1ps

module load_align
    import mem_stage_pkg::*;
(
    input  logic [31:0] rword,
    input  load_kind_t  load_kind,
    input  logic [1:0]  offset,
    output logic [31:0] rdata
);

    logic [15:0] half_sel;
    logic [7:0]  byte_sel;

    assign half_sel = offset[1] ? rword[31:16] : rword[15:0];
    assign byte_sel = rword[8*offset +: 8];   // lane 0..3

    always_comb begin
        case (load_kind)
            word: begin
                rdata = rword;
            end
            half_signed: begin
                rdata = {{16{half_sel[15]}}, half_sel};
            end
            half_unsigned: begin
                rdata = {16'h0, half_sel};
            end
            byte_signed: begin
                rdata = {{24{byte_sel[7]}}, byte_sel};
            end
            byte_unsigned: begin
                rdata = {24'h0, byte_sel};
            end
            default: begin
                rdata = 32'h0;                 // stores, faults, others
            end
        endcase
    end

endmodule

// ==== logic/data_ram.sv ====
`timescale 1ns/1ps

module data_ram
    import mem_stage_pkg::*;
(
    input  logic                  clk,
    input  logic                  en,
    input  logic [ram_addr_w-1:0] word_addr,
    input  logic [3:0]            byte_en,
    input  logic [31:0]           wdata,
    output logic [31:0]           rdata
);

    logic [31:0] mem [ram_words];            // contents not cleared
    logic [31:0] rdata_q = 32'h0;            // zero at power-up

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[word_addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            rdata_q <= mem[word_addr];         // old word, read before write
        end
    end

    // rdata holds while en is low, the response stage relies on it
    assign rdata = rdata_q;

    // lanes only move together with a pipeline transfer
    assert property (@(posedge clk) !en |-> byte_en == 4'b0000)
        else $error("byte_en active while RAM disabled");

endmodule

// ==== logic/pipe_stage.sv ====
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    // accept when empty or when the held item leaves this edge
    assign in_ready = ~valid_q | out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;               // refill or drain
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;                 // payload has no reset
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

    // a stalled item must not change under the consumer
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("out_data changed while stalled");

endmodule

// ==== logic/mem_control.sv ====
`timescale 1ns/1ps

module mem_control
    import mem_stage_pkg::*;
(
    input  logic [31:0] instr,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [3:0]  byte_en,
    output logic [31:0] store_data,
    output load_kind_t  load_kind,
    output logic        load_error,
    output logic        store_error
);

    logic [5:0] op_code;
    logic       is_lw;
    logic       is_lh;
    logic       is_lhu;
    logic       is_lb;
    logic       is_lbu;
    logic       is_sw;
    logic       is_sh;
    logic       is_sb;
    logic       word_aligned;
    logic       half_aligned;

    assign op_code = instr[31:26];

    assign is_lw  = (op_code == op_lw);
    assign is_lh  = (op_code == op_lh);
    assign is_lhu = (op_code == op_lhu);
    assign is_lb  = (op_code == op_lb);
    assign is_lbu = (op_code == op_lbu);
    assign is_sw  = (op_code == op_sw);
    assign is_sh  = (op_code == op_sh);
    assign is_sb  = (op_code == op_sb);

    assign word_aligned = (addr[1:0] == 2'b00);
    assign half_aligned = ~addr[0];            // offset 0 or 2

    // address errors, bytes never fault
    assign load_error  = (is_lw & ~word_aligned)
                       | ((is_lh | is_lhu) & ~half_aligned);
    assign store_error = (is_sw & ~word_aligned)
                       | (is_sh & ~half_aligned);

    // lane enables, misaligned stores fall through to zero
    always_comb begin
        byte_en = 4'b0000;
        if (is_sw && word_aligned) begin
            byte_en = 4'b1111;
        end else if (is_sh && half_aligned) begin
            byte_en = addr[1] ? 4'b1100 : 4'b0011;
        end else if (is_sb) begin
            byte_en = 4'b0001 << addr[1:0];
        end
    end

    // spread the store value over every lane it could land in
    always_comb begin
        store_data = 32'h0;
        if (is_sw) begin
            store_data = wdata;
        end else if (is_sh) begin
            store_data = {2{wdata[15:0]}};
        end else if (is_sb) begin
            store_data = {4{wdata[7:0]}};
        end
    end

    // a faulted load returns nothing
    always_comb begin
        load_kind = none;
        if (!load_error) begin
            if (is_lw) begin
                load_kind = word;
            end else if (is_lh) begin
                load_kind = half_signed;
            end else if (is_lhu) begin
                load_kind = half_unsigned;
            end else if (is_lb) begin
                load_kind = byte_signed;
            end else if (is_lbu) begin
                load_kind = byte_unsigned;
            end
        end
    end

    // the RAM must never see lanes for a faulted store
    always_comb begin
        assert (!(store_error && byte_en != 4'b0000))
            else $error("byte_en set on misaligned store");
        assert (!(load_error && store_error))
            else $error("load and store error at once");
    end

endmodule

// ==== logic/mem_stage_pkg.sv ====
package mem_stage_pkg;

    // MIPS primary opcodes, instr[31:26]
    localparam logic [5:0] op_lb  = 6'b100000;
    localparam logic [5:0] op_lh  = 6'b100001;
    localparam logic [5:0] op_lw  = 6'b100011;
    localparam logic [5:0] op_lbu = 6'b100100;
    localparam logic [5:0] op_lhu = 6'b100101;
    localparam logic [5:0] op_sb  = 6'b101000;
    localparam logic [5:0] op_sh  = 6'b101001;
    localparam logic [5:0] op_sw  = 6'b101011;

    // data memory geometry
    localparam int ram_words  = 256;
    localparam int ram_addr_w = 8;            // log2 of ram_words

    // how a returned word is trimmed and extended
    typedef enum logic [2:0] {
        none          = 3'd0,                 // store, other opcode or faulted load
        word          = 3'd1,
        half_signed   = 3'd2,
        half_unsigned = 3'd3,
        byte_signed   = 3'd4,
        byte_unsigned = 3'd5
    } load_kind_t;

    // request stage payload, built by mem_control
    typedef struct packed {
        logic [ram_addr_w-1:0] word_idx;      // addr[ram_addr_w+1:2]
        logic [3:0]            byte_en;       // lane write enables
        logic [31:0]           wdata;         // lane-replicated store data
        load_kind_t            load_kind;
        logic [1:0]            offset;        // byte offset in the word
        logic                  load_error;
        logic                  store_error;
    } req_payload_t;

    // response stage payload, read word comes from the RAM register
    typedef struct packed {
        load_kind_t load_kind;
        logic [1:0] offset;
        logic       load_error;
        logic       store_error;
    } resp_payload_t;

endpackage
